// ==== source/video_timing_pkg.sv ====
`default_nettype none

package video_timing_pkg;

    // ==================================================================
    // 1280x720 raster timing along a line in clocks.
    // ==================================================================
    localparam int H_SYNC  = 12;
    localparam int H_BP    = 277;
    localparam int H_ACT   = 1280;
    localparam int H_FP    = 323;
    localparam int H_TOTAL = H_SYNC + H_BP + H_ACT + H_FP;

    // ==================================================================
    // Vertical timing in lines.
    // ==================================================================
    localparam int V_SYNC  = 2;
    localparam int V_BP    = 11;
    localparam int V_ACT   = 720;
    localparam int V_FP    = 7;
    localparam int V_TOTAL = V_SYNC + V_BP + V_ACT + V_FP;

    // Active coordinate widths.
    localparam int X_BITS = 11;
    localparam int Y_BITS = 10;

endpackage : video_timing_pkg

`default_nettype wire

// ==== source/pixel_pkg.sv ====
`default_nettype none

package pixel_pkg;

    // Camera pixel and output colour widths.
    localparam int PIX_BITS   = 16;
    localparam int COLOR_BITS = 8;

    // RGB565 fields in the input pixel with red in the low bits.
    localparam int PX_R_BITS = 5;
    localparam int PX_G_BITS = 6;
    localparam int PX_B_BITS = 5;
    localparam int PX_R_LSB  = 0;
    localparam int PX_G_LSB  = PX_R_LSB + PX_R_BITS;
    localparam int PX_B_LSB  = PX_G_LSB + PX_G_BITS;

    // ==================================================================
    // Packed output word built up from the LSB.
    // ==================================================================
    localparam int PK_Y_LSB = 0;
    localparam int PK_X_LSB = PK_Y_LSB + video_timing_pkg::Y_BITS;
    localparam int PK_B_LSB = PK_X_LSB + video_timing_pkg::X_BITS;
    localparam int PK_G_LSB = PK_B_LSB + COLOR_BITS;
    localparam int PK_R_LSB = PK_G_LSB + COLOR_BITS;

    // Single-bit flags sit above the colour fields.
    localparam int PK_SOF   = PK_R_LSB + COLOR_BITS;
    localparam int PK_DE    = PK_SOF + 1;
    localparam int PK_HSYNC = PK_DE + 1;
    localparam int PK_VSYNC = PK_HSYNC + 1;

    // 49 bits in total.
    localparam int PACK_BITS = PK_VSYNC + 1;

endpackage : pixel_pkg

`default_nettype wire

// ==== source/sync_vg.sv ====
`default_nettype none

module sync_vg #(
    parameter int H_SYNC = video_timing_pkg::H_SYNC,
    parameter int H_BP   = video_timing_pkg::H_BP,
    parameter int H_ACT  = video_timing_pkg::H_ACT,
    parameter int H_FP   = video_timing_pkg::H_FP,
    parameter int V_SYNC = video_timing_pkg::V_SYNC,
    parameter int V_BP   = video_timing_pkg::V_BP,
    parameter int V_ACT  = video_timing_pkg::V_ACT,
    parameter int V_FP   = video_timing_pkg::V_FP,
    parameter int X_BITS = video_timing_pkg::X_BITS,
    parameter int Y_BITS = video_timing_pkg::Y_BITS
) (
    input  logic              clk,
    input  logic              rstn,
    output logic              o_vs,
    output logic              o_hs,
    output logic              o_de,
    output logic              o_sof,
    output logic [X_BITS-1:0] o_x,
    output logic [Y_BITS-1:0] o_y
);

    // ==================================================================
    // Totals and region boundaries.
    // ==================================================================
    localparam int H_TOTAL = H_SYNC + H_BP + H_ACT + H_FP;
    localparam int V_TOTAL = V_SYNC + V_BP + V_ACT + V_FP;
    localparam int HC_BITS = $clog2(H_TOTAL);
    localparam int VC_BITS = $clog2(V_TOTAL);

    localparam logic [HC_BITS-1:0] H_LAST     = HC_BITS'(H_TOTAL - 1);
    localparam logic [HC_BITS-1:0] H_SYNC_END = HC_BITS'(H_SYNC);
    localparam logic [HC_BITS-1:0] H_ACT_BEG  = HC_BITS'(H_SYNC + H_BP);
    localparam logic [HC_BITS-1:0] H_ACT_END  = HC_BITS'(H_SYNC + H_BP + H_ACT);

    localparam logic [VC_BITS-1:0] V_LAST     = VC_BITS'(V_TOTAL - 1);
    localparam logic [VC_BITS-1:0] V_SYNC_END = VC_BITS'(V_SYNC);
    localparam logic [VC_BITS-1:0] V_ACT_BEG  = VC_BITS'(V_SYNC + V_BP);
    localparam logic [VC_BITS-1:0] V_ACT_END  = VC_BITS'(V_SYNC + V_BP + V_ACT);

    logic [HC_BITS-1:0] h_cnt;
    logic [VC_BITS-1:0] v_cnt;
    logic               h_last;
    logic               v_last;
    logic               h_act;
    logic               v_act;
    logic               de_next;
    logic               sof_next;
    logic [X_BITS-1:0]  x_next;
    logic [Y_BITS-1:0]  y_next;

    // ==================================================================
    // Raster counters.
    // ==================================================================
    assign h_last = (h_cnt == H_LAST);
    assign v_last = (v_cnt == V_LAST);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else begin
            if (h_last) begin
                h_cnt <= '0;
                if (v_last) begin
                    v_cnt <= '0;
                end else begin
                    v_cnt <= v_cnt + 1'b1;
                end
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
        end
    end

    // ==================================================================
    // Window decode for the registered outputs.
    // ==================================================================
    assign h_act    = (h_cnt >= H_ACT_BEG) && (h_cnt < H_ACT_END);
    assign v_act    = (v_cnt >= V_ACT_BEG) && (v_cnt < V_ACT_END);
    assign de_next  = h_act && v_act;
    assign sof_next = (h_cnt == H_ACT_BEG) && (v_cnt == V_ACT_BEG);

    // Coordinates are forced to zero outside the active area.
    assign x_next = de_next ? X_BITS'(h_cnt - H_ACT_BEG) : '0;
    assign y_next = de_next ? Y_BITS'(v_cnt - V_ACT_BEG) : '0;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            o_hs  <= 1'b0;
            o_vs  <= 1'b0;
            o_de  <= 1'b0;
            o_sof <= 1'b0;
            o_x   <= '0;
            o_y   <= '0;
        end else begin
            o_hs  <= (h_cnt < H_SYNC_END);
            o_vs  <= (v_cnt < V_SYNC_END);
            o_de  <= de_next;
            o_sof <= sof_next;
            o_x   <= x_next;
            o_y   <= y_next;
        end
    end

endmodule : sync_vg

`default_nettype wire

// ==== source/hdmi_pack.sv ====
`default_nettype none

module hdmi_pack (
    input  logic                                 clk,
    input  logic                                 rstn,
    input  logic                                 i_vs,
    input  logic                                 i_hs,
    input  logic                                 i_de,
    input  logic                                 i_sof,
    input  logic [pixel_pkg::PIX_BITS-1:0]       i_pix,
    input  logic [video_timing_pkg::X_BITS-1:0]  i_x,
    input  logic [video_timing_pkg::Y_BITS-1:0]  i_y,
    output logic [pixel_pkg::PACK_BITS-1:0]      o_pack
);

    import video_timing_pkg::*;
    import pixel_pkg::*;

    logic [PX_R_BITS-1:0]  r5;
    logic [PX_G_BITS-1:0]  g6;
    logic [PX_B_BITS-1:0]  b5;
    logic [COLOR_BITS-1:0] r8;
    logic [COLOR_BITS-1:0] g8;
    logic [COLOR_BITS-1:0] b8;
    logic [PACK_BITS-1:0]  pack_next;

    // ==================================================================
    // RGB565 to RGB888.
    // ==================================================================
    assign r5 = i_pix[PX_R_LSB +: PX_R_BITS];
    assign g6 = i_pix[PX_G_LSB +: PX_G_BITS];
    assign b5 = i_pix[PX_B_LSB +: PX_B_BITS];

    // Low bits are zero-filled and the MSBs are not replicated.
    assign r8 = COLOR_BITS'(r5) << (COLOR_BITS - PX_R_BITS);
    assign g8 = COLOR_BITS'(g6) << (COLOR_BITS - PX_G_BITS);
    assign b8 = COLOR_BITS'(b5) << (COLOR_BITS - PX_B_BITS);

    // ==================================================================
    // Output word.
    // ==================================================================
    always_comb begin
        pack_next                         = '0;
        pack_next[PK_VSYNC]               = i_vs;
        pack_next[PK_HSYNC]               = i_hs;
        pack_next[PK_DE]                  = i_de;
        pack_next[PK_SOF]                 = i_sof;
        pack_next[PK_R_LSB +: COLOR_BITS] = r8;
        pack_next[PK_G_LSB +: COLOR_BITS] = g8;
        pack_next[PK_B_LSB +: COLOR_BITS] = b8;
        pack_next[PK_X_LSB +: X_BITS]     = i_x;
        pack_next[PK_Y_LSB +: Y_BITS]     = i_y;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            o_pack <= '0;
        end else begin
            o_pack <= pack_next;
        end
    end

endmodule : hdmi_pack

`default_nettype wire

// ==== source/hdmi_display.sv ====
`default_nettype none

module hdmi_display (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic                            i_vsync,
    input  logic [pixel_pkg::PIX_BITS-1:0]  i_data,
    output logic [pixel_pkg::PACK_BITS-1:0] o_pack
);

    import video_timing_pkg::*;
    import pixel_pkg::*;

    logic              vsync_q;
    logic              vsync_rise;
    logic              gen_rstn;
    logic [PIX_BITS-1:0] pix_q;
    logic              vg_vs;
    logic              vg_hs;
    logic              vg_de;
    logic              vg_sof;
    logic [X_BITS-1:0] vg_x;
    logic [Y_BITS-1:0] vg_y;

    // ==================================================================
    // Arming on the first rising edge of the camera vsync.
    // ==================================================================
    assign vsync_rise = !vsync_q && i_vsync;

    // One-shot that stays set until rstn falls.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            vsync_q  <= 1'b0;
            gen_rstn <= 1'b0;
        end else begin
            vsync_q  <= i_vsync;
            gen_rstn <= gen_rstn || vsync_rise;
        end
    end

    // Matches the output register stage of the generator.
    always_ff @(posedge clk) begin
        pix_q <= i_data;
    end

    sync_vg u_sync_vg (
        .clk   (clk),
        .rstn  (gen_rstn),
        .o_vs  (vg_vs),
        .o_hs  (vg_hs),
        .o_de  (vg_de),
        .o_sof (vg_sof),
        .o_x   (vg_x),
        .o_y   (vg_y)
    );

    hdmi_pack u_disp_pack (
        .clk    (clk),
        .rstn   (rstn),
        .i_vs   (vg_vs),
        .i_hs   (vg_hs),
        .i_de   (vg_de),
        .i_sof  (vg_sof),
        .i_pix  (pix_q),
        .i_x    (vg_x),
        .i_y    (vg_y),
        .o_pack (o_pack)
    );

endmodule : hdmi_display

`default_nettype wire

// ==== test/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen (
    output logic o_clk,
    output logic o_rstn
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_PERIOD = 10;
    localparam int RST_CYCLES  = 10;

    initial begin
        o_clk = 1'b0;
        forever #(HALF_PERIOD) o_clk = ~o_clk;
    end

    // Release just after an edge like the other stimulus.
    initial begin
        o_rstn = 1'b0;
        repeat (RST_CYCLES) @(posedge o_clk);
        #2;
        o_rstn = 1'b1;
    end

endmodule : tb_clock_gen

`default_nettype wire

// ==== test/tb_hdmi_display.sv ====
`default_nettype none

module tb_hdmi_display;

    timeunit 1ns;
    timeprecision 100ps;

    import video_timing_pkg::*;
    import pixel_pkg::*;

    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int VS_HIGH      = V_SYNC * H_TOTAL;
    localparam int CAM_PERIOD   = FRAME_CYCLES + 1000;
    localparam int RUN_STATES   = 2 * FRAME_CYCLES;
    localparam int PRE_ARM_MIN  = 20;
    localparam int PRE_ARM_MAX  = 200;
    localparam int RST_CYCLES   = 10;
    localparam int CLK_PERIOD   = 20;
    localparam int H_ACT_BEG    = H_SYNC + H_BP;
    localparam int V_ACT_BEG    = V_SYNC + V_BP;
    localparam longint WATCHDOG_NS =
        longint'(CLK_PERIOD) * (3 * FRAME_CYCLES + RST_CYCLES + PRE_ARM_MAX + 10);

    logic                 clk;
    logic                 rstn;
    logic                 i_vsync;
    logic [PIX_BITS-1:0]  i_data;
    logic [PACK_BITS-1:0] o_pack;

    integer               seed;
    int                   edge_n;
    int                   arm_edge;
    int                   since_rst;
    int                   pre_arm;
    int                   sof_count;
    int                   h_ref;
    int                   v_ref;
    bit                   armed;
    bit                   first_seen;
    bit                   done;
    logic                 vs_prev;
    logic [PIX_BITS-1:0]  applied [2];

    logic                  exp_vs;
    logic                  exp_hs;
    logic                  exp_de;
    logic                  exp_sof;
    logic [COLOR_BITS-1:0] exp_r;
    logic [COLOR_BITS-1:0] exp_g;
    logic [COLOR_BITS-1:0] exp_b;
    logic [X_BITS-1:0]     exp_x;
    logic [Y_BITS-1:0]     exp_y;

    tb_clock_gen u_clock_gen (
        .o_clk  (clk),
        .o_rstn (rstn)
    );

    hdmi_display UUT (
        .clk     (clk),
        .rstn    (rstn),
        .i_vsync (i_vsync),
        .i_data  (i_data),
        .o_pack  (o_pack)
    );

    // ==================================================================
    // Compare tasks.
    // ==================================================================
    task automatic check_sync(input string name, input logic exp_v, input logic act_v);
        if (act_v !== exp_v) begin
            $display("MISMATCH %s at edge %0d: expected %h, actual %h",
                     name, edge_n, exp_v, act_v);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Stopped at the first mismatch.");
        end
    endtask

    task automatic check_color(input string name, input logic [COLOR_BITS-1:0] exp_v,
                               input logic [COLOR_BITS-1:0] act_v);
        if (act_v !== exp_v) begin
            $display("MISMATCH %s at edge %0d: expected %h, actual %h",
                     name, edge_n, exp_v, act_v);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Stopped at the first mismatch.");
        end
    endtask

    task automatic check_coord(input logic [X_BITS-1:0] exp_xv, input logic [X_BITS-1:0] act_xv,
                               input logic [Y_BITS-1:0] exp_yv, input logic [Y_BITS-1:0] act_yv);
        if (act_xv !== exp_xv) begin
            $display("MISMATCH x at edge %0d: expected %h, actual %h", edge_n, exp_xv, act_xv);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Stopped at the first mismatch.");
        end
        if (act_yv !== exp_yv) begin
            $display("MISMATCH y at edge %0d: expected %h, actual %h", edge_n, exp_yv, act_yv);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Stopped at the first mismatch.");
        end
    endtask

    // ==================================================================
    // Reference model evaluated just after each rising edge.
    // ==================================================================
    task update_reference;
        if (!rstn) begin
            vs_prev = 1'b0;
        end else begin
            since_rst++;
            if (!armed && !vs_prev && i_vsync) begin
                armed    = 1'b1;
                arm_edge = edge_n;
            end
            vs_prev = i_vsync;
        end
        exp_vs  = 1'b0;
        exp_hs  = 1'b0;
        exp_de  = 1'b0;
        exp_sof = 1'b0;
        exp_x   = '0;
        exp_y   = '0;
        // Counter state two edges back drives the word seen now.
        if (rstn && armed && (edge_n - 2 >= arm_edge)) begin
            if (edge_n - 2 == arm_edge) begin
                h_ref = 0;
                v_ref = 0;
            end else if (h_ref == H_TOTAL - 1) begin
                h_ref = 0;
                v_ref = (v_ref == V_TOTAL - 1) ? 0 : v_ref + 1;
            end else begin
                h_ref++;
            end
            exp_hs = (h_ref < H_SYNC);
            exp_vs = (v_ref < V_SYNC);
            exp_de = (h_ref >= H_ACT_BEG) && (h_ref < H_ACT_BEG + H_ACT) &&
                     (v_ref >= V_ACT_BEG) && (v_ref < V_ACT_BEG + V_ACT);
            if (exp_de) begin
                exp_x = X_BITS'(h_ref - H_ACT_BEG);
                exp_y = Y_BITS'(v_ref - V_ACT_BEG);
            end
            exp_sof = exp_de && (exp_x == '0) && (exp_y == '0);
        end
        // RGB565 has red in the low bits and is zero-filled up to 8 bits.
        if (rstn) begin
            exp_r = {applied[1][4:0], 3'b000};
            exp_g = {applied[1][10:5], 2'b00};
            exp_b = {applied[1][15:11], 3'b000};
        end else begin
            exp_r = '0;
            exp_g = '0;
            exp_b = '0;
        end
    endtask

    task check_output;
        // Counter state 0,0 reaches the output two edges after the arming edge.
        if (!first_seen && o_pack[PK_VSYNC] && o_pack[PK_HSYNC]) begin
            first_seen = 1'b1;
            if (edge_n != arm_edge + 2) begin
                $display("First word with hsync and vsync came %0d edges after arming, not 3.",
                         edge_n + 1 - arm_edge);
                $display("TEST RESULT: FAIL");
                $fatal(1, "Arming latency wrong.");
            end
        end
        check_sync("vsync", exp_vs, o_pack[PK_VSYNC]);
        check_sync("hsync", exp_hs, o_pack[PK_HSYNC]);
        check_sync("de", exp_de, o_pack[PK_DE]);
        check_sync("sof", exp_sof, o_pack[PK_SOF]);
        check_color("red", exp_r, o_pack[PK_R_LSB +: COLOR_BITS]);
        check_color("green", exp_g, o_pack[PK_G_LSB +: COLOR_BITS]);
        check_color("blue", exp_b, o_pack[PK_B_LSB +: COLOR_BITS]);
        check_coord(exp_x, o_pack[PK_X_LSB +: X_BITS], exp_y, o_pack[PK_Y_LSB +: Y_BITS]);
        if (o_pack[PK_SOF]) begin
            sof_count++;
        end
    endtask

    task drive_inputs;
        logic [31:0] rnd;
        rnd        = $random(seed);
        i_data     = rnd[PIX_BITS-1:0];
        applied[1] = applied[0];
        applied[0] = i_data;
        // Camera frame period is a little longer than the raster.
        if (since_rst < pre_arm) begin
            i_vsync = 1'b0;
        end else begin
            i_vsync = (((since_rst - pre_arm) % CAM_PERIOD) < VS_HIGH);
        end
    endtask

    // ==================================================================
    // Main sequence and watchdog.
    // ==================================================================
    initial begin
        seed       = 32'h53d4_224c;
        i_vsync    = 1'b0;
        i_data     = '0;
        applied[0] = '0;
        applied[1] = '0;
        edge_n     = 0;
        arm_edge   = 0;
        since_rst  = 0;
        sof_count  = 0;
        h_ref      = 0;
        v_ref      = 0;
        armed      = 1'b0;
        first_seen = 1'b0;
        done       = 1'b0;
        vs_prev    = 1'b0;
        pre_arm    = PRE_ARM_MIN +
                     int'($unsigned($random(seed)) % (PRE_ARM_MAX - PRE_ARM_MIN + 1));
        $display("Camera vsync held low for %0d cycles after reset.", pre_arm);
        while (!done) begin
            @(posedge clk);
            edge_n++;
            #1;
            update_reference();
            check_output();
            if (armed && (edge_n - 2 - arm_edge == RUN_STATES - 1)) begin
                done = 1'b1;
            end
            #1;
            drive_inputs();
        end
        if (sof_count != 2) begin
            $display("Start of frame seen %0d times over two frames, expected 2.", sof_count);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Frame marker count wrong.");
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: two frames were not completed in the allowed time.");
        $display("TEST RESULT: FAIL");
        $fatal(1, "Watchdog expired.");
    end

endmodule : tb_hdmi_display

`default_nettype wire

// ==== src.f ====
source/video_timing_pkg.sv
source/pixel_pkg.sv
source/sync_vg.sv
source/hdmi_pack.sv
source/hdmi_display.sv
test/tb_clock_gen.sv
test/tb_hdmi_display.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the hdmi_display testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir
BIN=sim_hdmi_display

verilator --binary --timing --timescale 1ns/100ps \
    -f src.f --top-module tb_hdmi_display \
    -Mdir "$BUILD_DIR" -o "$BIN"
if [ $? -ne 0 ]; then
    echo "Build failed."
    exit 1
fi

"./$BUILD_DIR/$BIN" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "TEST RESULT: FAIL" "$LOG"; then
    echo "Simulation failed."
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "Simulator exited with status $run_status."
    exit 1
fi
echo "Simulation passed."
exit 0
